// ==== verilog/glb_types_pkg.sv ====
/*
 * Datapath widths sized for 4 banks of 64 words and 2 ports per direction.
 * Widen the index types together with the top-level parameters.
 */
package glb_types_pkg;

    // Bank word and per-bank word address
    localparam int GLB_WORD_W  = 32;
    localparam int GLB_WADDR_W = 6;

    // Relative bank index and port index
    localparam int GLB_BIDX_W  = 2;
    localparam int GLB_PIDX_W  = 1;

    // Port address holds the relative bank above the word address
    localparam int GLB_PADDR_W = GLB_BIDX_W + GLB_WADDR_W;

    typedef logic [GLB_WORD_W-1:0]  glb_word_t;
    typedef logic [GLB_WADDR_W-1:0] glb_waddr_t;
    typedef logic [GLB_PADDR_W-1:0] glb_paddr_t;
    typedef logic [GLB_BIDX_W-1:0]  glb_bank_idx_t;
    typedef logic [GLB_PIDX_W-1:0]  glb_port_idx_t;

    // Relative bank field of a port address
    function automatic glb_bank_idx_t paddr_bank(glb_paddr_t addr);
        return addr[GLB_WADDR_W +: GLB_BIDX_W];
    endfunction

    // Word field of a port address
    function automatic glb_waddr_t paddr_word(glb_paddr_t addr);
        return addr[GLB_WADDR_W-1:0];
    endfunction

endpackage

// ==== verilog/glb_ctrl_pkg.sv ====
/*
 * Controller state encoding and bank-map flag type.
 * GLB_MAP_W must equal NUM_BANK of the top level.
 */
package glb_ctrl_pkg;

    // Number of bank-map entries
    localparam int GLB_MAP_W = 4;

    // Controller states
    typedef enum logic [1:0] {
        GLB_IDLE = 2'd0,
        GLB_CFG  = 2'd1,
        GLB_CMP  = 2'd2
    } glb_state_e;

    // One mapped flag per bank
    typedef logic [GLB_MAP_W-1:0] glb_map_valid_t;

endpackage

// ==== verilog/glb_bank.sv ====
/*
 * Single SRAM bank with one read port, one write port and a registered read.
 * Contents are undefined after reset. Read and write to one address in
 * the same cycle returns the old word.
 */
`timescale 1ns/1ps

module glb_bank import glb_types_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rd_en,
    input  glb_waddr_t rd_addr,
    input  logic       wr_en,
    input  glb_waddr_t wr_addr,
    input  glb_word_t  wr_dat,
    output glb_word_t  rd_dat
);

    localparam int DEPTH = 1 << GLB_WADDR_W;

    // Storage array
    glb_word_t mem [DEPTH];

    // ========================================================================
    // Array access
    // ========================================================================

    // Write lands at the edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_dat;
        end
    end

    // Read register holds the last word until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_dat <= mem[rd_addr];
        end
    end

    // Enabled accesses carry a known word address
    a_rd_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> !$isunknown(rd_addr));

    a_wr_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_addr));

endmodule

// ==== verilog/glb_wr_router.sv ====
/*
 * Write steering from ports to banks through the bank map.
 * A read on the target bank stalls the write. Writes to an address with
 * no owned bank are accepted and dropped.
 */
`timescale 1ns/1ps

module glb_wr_router import glb_types_pkg::*; #(
    parameter int NUM_BANK   = 4,
    parameter int NUM_WRPORT = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmp_active,
    input  logic [NUM_BANK-1:0]   map_valid,
    input  glb_port_idx_t         map_wr_port [NUM_BANK],
    input  glb_bank_idx_t         map_rel_idx [NUM_BANK],
    input  logic [NUM_WRPORT-1:0] wr_vld,
    input  glb_paddr_t            wr_addr [NUM_WRPORT],
    input  glb_word_t             wr_dat [NUM_WRPORT],
    input  logic [NUM_BANK-1:0]   bank_rd_busy,
    output logic [NUM_WRPORT-1:0] wr_rdy,
    output logic [NUM_BANK-1:0]   bank_wr_en,
    output glb_waddr_t            bank_wr_addr [NUM_BANK],
    output glb_word_t             bank_wr_dat [NUM_BANK]
);

    // Owning port addresses this bank
    logic [NUM_BANK-1:0]   own_hit;
    // Port target held by a read this cycle
    logic [NUM_WRPORT-1:0] wr_stall;

    // ========================================================================
    // Bank side
    // ========================================================================

    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        glb_port_idx_t owner;

        assign owner = map_wr_port[b];

        // Relative bank of the owner's address must match this bank's slot
        assign own_hit[b] = map_valid[b] &&
                            (paddr_bank(wr_addr[owner]) == map_rel_idx[b]);

        // Write lands only when the owner's request is accepted
        assign bank_wr_en[b]   = wr_vld[owner] && wr_rdy[owner] && own_hit[b];
        assign bank_wr_addr[b] = paddr_word(wr_addr[owner]);
        assign bank_wr_dat[b]  = wr_dat[owner];

        a_no_wr_on_rd: assert property (@(posedge clk) disable iff (!rst_n)
            bank_rd_busy[b] |-> !bank_wr_en[b]);
    end

    // ========================================================================
    // Port side
    // ========================================================================

    // Stall when the port's target bank is mapped and being read
    always_comb begin
        for (int j = 0; j < NUM_WRPORT; j++) begin
            wr_stall[j] = 1'b0;
            for (int b = 0; b < NUM_BANK; b++) begin
                if (own_hit[b] && bank_rd_busy[b] &&
                    map_wr_port[b] == glb_port_idx_t'(j)) begin
                    wr_stall[j] = 1'b1;
                end
            end
        end
    end

    // Ready only in compute
    assign wr_rdy = {NUM_WRPORT{cmp_active}} & ~wr_stall;

endmodule

// ==== verilog/glb_rd_router.sv ====
/*
 * Read steering from ports to banks with a one-cycle return.
 * Each bank has a single read owner, so ports never compete.
 * Unmapped addresses return zero with the usual valid strobe.
 */
`timescale 1ns/1ps

module glb_rd_router import glb_types_pkg::*; #(
    parameter int NUM_BANK   = 4,
    parameter int NUM_RDPORT = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmp_active,
    input  logic [NUM_BANK-1:0]   map_valid,
    input  glb_port_idx_t         map_rd_port [NUM_BANK],
    input  glb_bank_idx_t         map_rel_idx [NUM_BANK],
    input  logic [NUM_RDPORT-1:0] rd_vld,
    input  glb_paddr_t            rd_addr [NUM_RDPORT],
    input  glb_word_t             bank_rd_dat [NUM_BANK],
    output logic [NUM_RDPORT-1:0] rd_rdy,
    output logic [NUM_BANK-1:0]   bank_rd_en,
    output glb_waddr_t            bank_rd_addr [NUM_BANK],
    output logic [NUM_BANK-1:0]   bank_rd_busy,
    output logic [NUM_RDPORT-1:0] rd_dat_vld,
    output glb_word_t             rd_dat [NUM_RDPORT]
);

    // Accepted requests and which bank serves them
    logic [NUM_RDPORT-1:0] rd_acc;
    logic [NUM_RDPORT-1:0] rd_hit;
    glb_bank_idx_t         rd_sel [NUM_RDPORT];

    // Return stage
    logic [NUM_RDPORT-1:0] hit_q;
    glb_bank_idx_t         sel_q [NUM_RDPORT];

    assign rd_rdy = {NUM_RDPORT{cmp_active}};
    assign rd_acc = rd_vld & rd_rdy;

    // ========================================================================
    // Request decode
    // ========================================================================

    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        glb_port_idx_t owner;

        assign owner = map_rd_port[b];

        assign bank_rd_en[b]   = rd_acc[owner] && map_valid[b] &&
                                 (paddr_bank(rd_addr[owner]) == map_rel_idx[b]);
        assign bank_rd_addr[b] = paddr_word(rd_addr[owner]);

        // Write side backs off this bank
        assign bank_rd_busy[b] = bank_rd_en[b];
    end

    // At most one serving bank per port
    always_comb begin
        for (int j = 0; j < NUM_RDPORT; j++) begin
            rd_hit[j] = 1'b0;
            rd_sel[j] = '0;
            for (int b = 0; b < NUM_BANK; b++) begin
                if (bank_rd_en[b] && map_rd_port[b] == glb_port_idx_t'(j)) begin
                    rd_hit[j] = 1'b1;
                    rd_sel[j] = glb_bank_idx_t'(b);
                end
            end
        end
    end

    // ========================================================================
    // Return path
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_dat_vld <= '0;
            hit_q      <= '0;
        end else begin
            rd_dat_vld <= rd_acc;
            hit_q      <= rd_hit;
        end
    end

    // Bank select only matters when hit_q is set
    always_ff @(posedge clk) begin
        rd_sel_reg: for (int j = 0; j < NUM_RDPORT; j++) begin
            sel_q[j] <= rd_sel[j];
        end
    end

    for (genvar j = 0; j < NUM_RDPORT; j++) begin : g_port
        // Banks read for this port this cycle
        logic [NUM_BANK-1:0] served;

        for (genvar b = 0; b < NUM_BANK; b++) begin : g_served
            assign served[b] = bank_rd_en[b] && (map_rd_port[b] == glb_port_idx_t'(j));
        end

        // Zero for unmapped addresses
        assign rd_dat[j] = hit_q[j] ? bank_rd_dat[sel_q[j]] : '0;

        // Two entries with one owner and one relative slot would both fire
        a_one_bank: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(served));
    end

endmodule

// ==== verilog/glb_ctrl.sv ====
/*
 * Global buffer controller with bank map and completion tracking.
 * start is honoured only in IDLE and clears the map. Map entries are taken
 * only in CFG. fnh pulses once all read ports have reported done.
 */
`timescale 1ns/1ps

module glb_ctrl import glb_types_pkg::*, glb_ctrl_pkg::*; #(
    parameter int NUM_BANK   = 4,
    parameter int NUM_RDPORT = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  cfg_vld,
    input  logic                  cfg_last,
    input  glb_bank_idx_t         cfg_bank,
    input  glb_port_idx_t         cfg_wr_port,
    input  glb_port_idx_t         cfg_rd_port,
    input  glb_bank_idx_t         cfg_rel_idx,
    input  logic [NUM_RDPORT-1:0] rd_done,
    output logic                  busy,
    output logic                  fnh,
    output logic                  cmp_active,
    output glb_map_valid_t        map_valid,
    output glb_port_idx_t         map_wr_port [NUM_BANK],
    output glb_port_idx_t         map_rd_port [NUM_BANK],
    output glb_bank_idx_t         map_rel_idx [NUM_BANK]
);

    glb_state_e            state;
    glb_state_e            state_nxt;

    // Sticky done flags, one per read port
    logic [NUM_RDPORT-1:0] done_q;
    logic                  all_done;
    logic                  start_acc;
    logic                  cfg_wr;

    assign start_acc  = (state == GLB_IDLE) && start;
    assign cfg_wr     = (state == GLB_CFG) && cfg_vld;
    // Includes this cycle's pulses
    assign all_done   = &(done_q | rd_done);

    assign busy       = (state != GLB_IDLE);
    assign cmp_active = (state == GLB_CMP);

    // ========================================================================
    // FSM
    // ========================================================================

    always_comb begin
        state_nxt = state;
        case (state)
            GLB_IDLE: begin
                if (start) begin
                    state_nxt = GLB_CFG;
                end
            end
            GLB_CFG: begin
                // With or without an entry in the same cycle
                if (cfg_last) begin
                    state_nxt = GLB_CMP;
                end
            end
            GLB_CMP: begin
                if (all_done) begin
                    state_nxt = GLB_IDLE;
                end
            end
            default: state_nxt = GLB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= GLB_IDLE;
            fnh    <= 1'b0;
            done_q <= '0;
        end else begin
            state <= state_nxt;
            // One cycle after the last done
            fnh   <= cmp_active && all_done;
            if (start_acc) begin
                done_q <= '0;
            end else if (cmp_active) begin
                done_q <= done_q | rd_done;
            end
        end
    end

    // ========================================================================
    // Bank map
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            map_valid <= '0;
        end else if (start_acc) begin
            map_valid <= '0;
        end else if (cfg_wr) begin
            map_valid[cfg_bank] <= 1'b1;
        end
    end

    // Entry fields, qualified by map_valid
    always_ff @(posedge clk) begin
        if (cfg_wr) begin
            map_wr_port[cfg_bank] <= cfg_wr_port;
            map_rd_port[cfg_bank] <= cfg_rd_port;
            map_rel_idx[cfg_bank] <= cfg_rel_idx;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {GLB_IDLE, GLB_CFG, GLB_CMP});

    // Finish lands in IDLE and never stretches
    a_fnh_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        fnh |-> !busy ##1 !fnh);

endmodule

// ==== verilog/glb_top.sv ====
/*
 * Global on-chip buffer top level, banks shared by write and read ports.
 * Package widths fit the default parameters only.
 */
`timescale 1ns/1ps

module glb_top import glb_types_pkg::*, glb_ctrl_pkg::*; #(
    parameter int NUM_BANK   = 4,
    parameter int NUM_WRPORT = 2,
    parameter int NUM_RDPORT = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Host configuration
    input  logic                  start,
    input  logic                  cfg_vld,
    input  logic                  cfg_last,
    input  glb_bank_idx_t         cfg_bank,
    input  glb_port_idx_t         cfg_wr_port,
    input  glb_port_idx_t         cfg_rd_port,
    input  glb_bank_idx_t         cfg_rel_idx,
    // Write ports
    input  logic [NUM_WRPORT-1:0] wr_vld,
    input  glb_paddr_t            wr_addr [NUM_WRPORT],
    input  glb_word_t             wr_dat [NUM_WRPORT],
    output logic [NUM_WRPORT-1:0] wr_rdy,
    // Read ports
    input  logic [NUM_RDPORT-1:0] rd_vld,
    input  glb_paddr_t            rd_addr [NUM_RDPORT],
    output logic [NUM_RDPORT-1:0] rd_rdy,
    output logic [NUM_RDPORT-1:0] rd_dat_vld,
    output glb_word_t             rd_dat [NUM_RDPORT],
    input  logic [NUM_RDPORT-1:0] rd_done,
    // Status
    output logic                  busy,
    output logic                  fnh
);

    // Map from controller
    logic                cmp_active;
    glb_map_valid_t      map_valid;
    glb_port_idx_t       map_wr_port [NUM_BANK];
    glb_port_idx_t       map_rd_port [NUM_BANK];
    glb_bank_idx_t       map_rel_idx [NUM_BANK];

    // Bank side buses
    logic [NUM_BANK-1:0] bank_rd_en;
    glb_waddr_t          bank_rd_addr [NUM_BANK];
    logic [NUM_BANK-1:0] bank_rd_busy;
    glb_word_t           bank_rd_dat [NUM_BANK];
    logic [NUM_BANK-1:0] bank_wr_en;
    glb_waddr_t          bank_wr_addr [NUM_BANK];
    glb_word_t           bank_wr_dat [NUM_BANK];

    // ========================================================================
    // Control
    // ========================================================================

    glb_ctrl #(
        .NUM_BANK   (NUM_BANK),
        .NUM_RDPORT (NUM_RDPORT)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .cfg_vld     (cfg_vld),
        .cfg_last    (cfg_last),
        .cfg_bank    (cfg_bank),
        .cfg_wr_port (cfg_wr_port),
        .cfg_rd_port (cfg_rd_port),
        .cfg_rel_idx (cfg_rel_idx),
        .rd_done     (rd_done),
        .busy        (busy),
        .fnh         (fnh),
        .cmp_active  (cmp_active),
        .map_valid   (map_valid),
        .map_wr_port (map_wr_port),
        .map_rd_port (map_rd_port),
        .map_rel_idx (map_rel_idx)
    );

    // ========================================================================
    // Routers and banks
    // ========================================================================

    glb_wr_router #(
        .NUM_BANK   (NUM_BANK),
        .NUM_WRPORT (NUM_WRPORT)
    ) u_wr_router (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmp_active   (cmp_active),
        .map_valid    (map_valid),
        .map_wr_port  (map_wr_port),
        .map_rel_idx  (map_rel_idx),
        .wr_vld       (wr_vld),
        .wr_addr      (wr_addr),
        .wr_dat       (wr_dat),
        .bank_rd_busy (bank_rd_busy),
        .wr_rdy       (wr_rdy),
        .bank_wr_en   (bank_wr_en),
        .bank_wr_addr (bank_wr_addr),
        .bank_wr_dat  (bank_wr_dat)
    );

    glb_rd_router #(
        .NUM_BANK   (NUM_BANK),
        .NUM_RDPORT (NUM_RDPORT)
    ) u_rd_router (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmp_active   (cmp_active),
        .map_valid    (map_valid),
        .map_rd_port  (map_rd_port),
        .map_rel_idx  (map_rel_idx),
        .rd_vld       (rd_vld),
        .rd_addr      (rd_addr),
        .bank_rd_dat  (bank_rd_dat),
        .rd_rdy       (rd_rdy),
        .bank_rd_en   (bank_rd_en),
        .bank_rd_addr (bank_rd_addr),
        .bank_rd_busy (bank_rd_busy),
        .rd_dat_vld   (rd_dat_vld),
        .rd_dat       (rd_dat)
    );

    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        glb_bank u_bank (
            .clk     (clk),
            .rst_n   (rst_n),
            .rd_en   (bank_rd_en[b]),
            .rd_addr (bank_rd_addr[b]),
            .wr_en   (bank_wr_en[b]),
            .wr_addr (bank_wr_addr[b]),
            .wr_dat  (bank_wr_dat[b]),
            .rd_dat  (bank_rd_dat[b])
        );
    end

endmodule

// ==== verification/glb_tb_clkgen.sv ====
/*
 * Testbench clock and reset source, 100 ns period.
 * Reset is low for the first two rising edges and released 1 ns later.
 */
`timescale 1ns/1ps

module glb_tb_clkgen #(
    parameter int HALF_PERIOD = 50,
    parameter int RST_CYCLES  = 2
) (
    output logic clk,
    output logic rst_n
);

    // Free running clock
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release off the edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== verification/glb_tb.sv ====
/*
 * Golden-file driven testbench for the global buffer top level.
 * Inputs change 1 ns after the rising edge and outputs are sampled at the
 * falling edge. Operations come from verification/glb_golden.txt.
 */
`timescale 1ns/1ps

module glb_tb
    import glb_types_pkg::*;
();

    localparam int NUM_BANK   = 4;
    localparam int NUM_WRPORT = 2;
    localparam int NUM_RDPORT = 2;
    localparam int MAX_OPS    = 64;

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    logic                  cfg_vld;
    logic                  cfg_last;
    glb_bank_idx_t         cfg_bank;
    glb_port_idx_t         cfg_wr_port;
    glb_port_idx_t         cfg_rd_port;
    glb_bank_idx_t         cfg_rel_idx;
    logic [NUM_WRPORT-1:0] wr_vld;
    glb_paddr_t            wr_addr [NUM_WRPORT];
    glb_word_t             wr_dat [NUM_WRPORT];
    logic [NUM_WRPORT-1:0] wr_rdy;
    logic [NUM_RDPORT-1:0] rd_vld;
    glb_paddr_t            rd_addr [NUM_RDPORT];
    logic [NUM_RDPORT-1:0] rd_rdy;
    logic [NUM_RDPORT-1:0] rd_dat_vld;
    glb_word_t             rd_dat [NUM_RDPORT];
    logic [NUM_RDPORT-1:0] rd_done;
    logic                  busy;
    logic                  fnh;

    // Golden operations as a name plus up to six hex fields
    logic [63:0]           op_name [MAX_OPS];
    logic [31:0]           op_arg [MAX_OPS][6];
    int                    n_ops;

    int                    errors;
    int                    checks;
    int                    cycles = 0;
    int                    cycle_limit = 200;
    integer                seed;

    glb_tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    glb_top #(
        .NUM_BANK   (NUM_BANK),
        .NUM_WRPORT (NUM_WRPORT),
        .NUM_RDPORT (NUM_RDPORT)
    ) glb_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .cfg_vld     (cfg_vld),
        .cfg_last    (cfg_last),
        .cfg_bank    (cfg_bank),
        .cfg_wr_port (cfg_wr_port),
        .cfg_rd_port (cfg_rd_port),
        .cfg_rel_idx (cfg_rel_idx),
        .wr_vld      (wr_vld),
        .wr_addr     (wr_addr),
        .wr_dat      (wr_dat),
        .wr_rdy      (wr_rdy),
        .rd_vld      (rd_vld),
        .rd_addr     (rd_addr),
        .rd_rdy      (rd_rdy),
        .rd_dat_vld  (rd_dat_vld),
        .rd_dat      (rd_dat),
        .rd_done     (rd_done),
        .busy        (busy),
        .fnh         (fnh)
    );

    // ========================================================================
    // Reporting
    // ========================================================================

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED time %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("ERROR time %0t: %s", $time, msg);
    endtask

    // Watchdog limit is set once the golden file is loaded
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: DUT stopped responding, run ended after %0d cycles", cycles);
            $display("Checks run: %0d, errors: %0d", checks, errors + 1);
            $display("Finished with errors");
            $finish;
        end
    end

    // ========================================================================
    // Golden file
    // ========================================================================

    function automatic int arg_count(input logic [63:0] tok);
        case (tok)
            "cfg":            return 4;
            "write", "read":  return 3;
            "collide":        return 6;
            "done":           return 1;
            default:          return 0;
        endcase
    endfunction

    task automatic load_golden();
        integer           fd;
        integer           code;
        logic [63:0]      tok;
        logic [31:0]      val;
        logic [8*160-1:0] rest;
        int               nargs;
        n_ops = 0;
        fd = $fopen("verification/glb_golden.txt", "r");
        if (fd == 0) begin
            report_problem("golden file verification/glb_golden.txt could not be opened");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                // Drop the rest of a comment line
                if (tok == "#") begin
                    code = $fgets(rest, fd);
                end else if (n_ops < MAX_OPS) begin
                    op_name[n_ops] = tok;
                    nargs = arg_count(tok);
                    for (int k = 0; k < 6; k++) begin
                        op_arg[n_ops][k] = '0;
                    end
                    for (int k = 0; k < nargs; k++) begin
                        code = $fscanf(fd, "%h", val);
                        if (code != 1) begin
                            report_problem("golden file operation is missing a field");
                        end
                        op_arg[n_ops][k] = val;
                    end
                    n_ops++;
                end else begin
                    report_problem("golden file holds more operations than can be stored");
                end
            end
            $fclose(fd);
        end
    endtask

    // ========================================================================
    // Bus operations
    // ========================================================================

    // Drive point is 1 ns past the rising edge
    task automatic advance_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_gap();
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) advance_cycle();
    endtask

    task automatic check_rdy_low();
        check_value("wr_rdy", 32'(wr_rdy), 32'd0);
        check_value("rd_rdy", 32'(rd_rdy), 32'd0);
    endtask

    task automatic pulse_start();
        start = 1'b1;
        advance_cycle();
        start = 1'b0;
        @(negedge clk);
        check_value("busy", 32'(busy), 32'd1);
        check_rdy_low();
        advance_cycle();
    endtask

    task automatic load_map_entry(input glb_bank_idx_t bank, input glb_port_idx_t wp,
                                  input glb_port_idx_t rp, input glb_bank_idx_t rel);
        cfg_vld     = 1'b1;
        cfg_bank    = bank;
        cfg_wr_port = wp;
        cfg_rd_port = rp;
        cfg_rel_idx = rel;
        @(negedge clk);
        check_rdy_low();
        advance_cycle();
        cfg_vld = 1'b0;
    endtask

    task automatic end_config();
        cfg_last = 1'b1;
        @(negedge clk);
        check_rdy_low();
        advance_cycle();
        cfg_last = 1'b0;
    endtask

    // Hold the write from a falling edge until wr_rdy is seen
    task automatic finish_write(input int port);
        while (wr_rdy[port] !== 1'b1) begin
            @(negedge clk);
        end
        advance_cycle();
        wr_vld[port] = 1'b0;
    endtask

    task automatic issue_write(input int port, input glb_paddr_t addr, input glb_word_t data);
        wr_vld[port]  = 1'b1;
        wr_addr[port] = addr;
        wr_dat[port]  = data;
        @(negedge clk);
        finish_write(port);
    endtask

    // Data is due one cycle after the accepting edge
    task automatic collect_read(input int port, input glb_word_t expected);
        @(negedge clk);
        if (rd_dat_vld[port] !== 1'b1) begin
            report_problem($sformatf("no rd_dat_vld on read port %0d after acceptance", port));
        end else begin
            check_value("rd_dat", rd_dat[port], expected);
        end
    endtask

    task automatic issue_read(input int port, input glb_paddr_t addr, input glb_word_t expected);
        rd_vld[port]  = 1'b1;
        rd_addr[port] = addr;
        @(negedge clk);
        // Nothing returns ahead of acceptance
        check_value("rd_dat_vld", 32'(rd_dat_vld[port]), 32'd0);
        while (rd_rdy[port] !== 1'b1) begin
            @(negedge clk);
        end
        advance_cycle();
        rd_vld[port] = 1'b0;
        collect_read(port, expected);
        advance_cycle();
    endtask

    // Read and write on one bank in one cycle where the read must win
    task automatic issue_collision(input int wp, input glb_paddr_t wa, input glb_word_t wd,
                                   input int rp, input glb_paddr_t ra, input glb_word_t expected);
        wr_vld[wp]  = 1'b1;
        wr_addr[wp] = wa;
        wr_dat[wp]  = wd;
        rd_vld[rp]  = 1'b1;
        rd_addr[rp] = ra;
        @(negedge clk);
        check_value("rd_rdy", 32'(rd_rdy[rp]), 32'd1);
        check_value("wr_rdy", 32'(wr_rdy[wp]), 32'd0);
        advance_cycle();
        rd_vld[rp] = 1'b0;
        collect_read(rp, expected);
        finish_write(wp);
    endtask

    task automatic signal_done(input int port);
        rd_done[port] = 1'b1;
        advance_cycle();
        rd_done[port] = 1'b0;
    endtask

    // Single fnh pulse right after the last done
    task automatic expect_finish();
        @(negedge clk);
        if (fnh !== 1'b1) begin
            report_problem("fnh did not pulse after rd_done on all read ports");
        end
        check_value("busy", 32'(busy), 32'd0);
        advance_cycle();
        @(negedge clk);
        check_value("fnh", 32'(fnh), 32'd0);
        advance_cycle();
    endtask

    task automatic run_op(input int i);
        case (op_name[i])
            "start":   pulse_start();
            "cfg":     load_map_entry(op_arg[i][0][1:0], op_arg[i][1][0:0],
                                      op_arg[i][2][0:0], op_arg[i][3][1:0]);
            "last":    end_config();
            "write":   issue_write(op_arg[i][0], op_arg[i][1][7:0], op_arg[i][2]);
            "read":    issue_read(op_arg[i][0], op_arg[i][1][7:0], op_arg[i][2]);
            "collide": issue_collision(op_arg[i][0], op_arg[i][1][7:0], op_arg[i][2],
                                       op_arg[i][3], op_arg[i][4][7:0], op_arg[i][5]);
            "done":    signal_done(op_arg[i][0]);
            "fin":     expect_finish();
            default:   report_problem($sformatf("unknown operation %0s in golden file",
                                                op_name[i]));
        endcase
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        start       = 1'b0;
        cfg_vld     = 1'b0;
        cfg_last    = 1'b0;
        cfg_bank    = '0;
        cfg_wr_port = '0;
        cfg_rd_port = '0;
        cfg_rel_idx = '0;
        wr_vld      = '0;
        rd_vld      = '0;
        rd_done     = '0;
        for (int j = 0; j < NUM_WRPORT; j++) begin
            wr_addr[j] = '0;
            wr_dat[j]  = '0;
        end
        for (int j = 0; j < NUM_RDPORT; j++) begin
            rd_addr[j] = '0;
        end
        errors = 0;
        checks = 0;
        seed   = 32'h8930_4870;

        load_golden();
        cycle_limit = n_ops * 8 + 200;

        // Quiet outputs out of reset
        @(posedge rst_n);
        @(negedge clk);
        check_rdy_low();
        check_value("rd_dat_vld", 32'(rd_dat_vld), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
        check_value("fnh", 32'(fnh), 32'd0);
        advance_cycle();

        for (int i = 0; i < n_ops; i++) begin
            // fnh follows the last done without a gap
            if (op_name[i] != "fin") begin
                idle_gap();
            end
            run_op(i);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== verification/glb_golden.txt ====
# columns: op then hex fields; cfg bank wr_port rd_port rel_idx; done port
# write/read port addr data; collide wport waddr wdata rport raddr expected
start
cfg 0 0 0 0
cfg 1 0 0 1
cfg 2 1 1 0
cfg 3 1 1 1
last
write 0 05 deadbeef
read 0 05 deadbeef
write 0 45 11112222
write 1 05 33334444
write 1 7f 55556666
read 1 05 33334444
read 0 45 11112222
read 1 7f 55556666
read 0 05 deadbeef
write 0 03 0a0a0a0a
write 0 83 badbad00
read 0 03 0a0a0a0a
read 0 83 00000000
read 1 c0 00000000
collide 0 05 cafef00d 0 05 deadbeef
read 0 05 cafef00d
collide 1 05 77778888 1 05 33334444
read 1 05 77778888
done 0
done 1
fin
start
cfg 2 0 0 0
last
read 1 05 00000000
read 0 05 77778888
read 0 45 00000000
done 1
done 0
fin

// ==== compile.f ====
verilog/glb_types_pkg.sv
verilog/glb_ctrl_pkg.sv
verilog/glb_bank.sv
verilog/glb_wr_router.sv
verilog/glb_rd_router.sv
verilog/glb_ctrl.sv
verilog/glb_top.sv
verification/glb_tb_clkgen.sv
verification/glb_tb.sv

// ==== Bender.yml ====
package:
  name: glb

sources:
  # RTL
  - files:
      - verilog/glb_types_pkg.sv
      - verilog/glb_ctrl_pkg.sv
      - verilog/glb_bank.sv
      - verilog/glb_wr_router.sv
      - verilog/glb_rd_router.sv
      - verilog/glb_ctrl.sv
      - verilog/glb_top.sv

  # Testbench
  - target: test
    files:
      - verification/glb_tb_clkgen.sv
      - verification/glb_tb.sv
